// ==== digitizer_pkg.sv ====
`default_nettype none

// Shared types and sizes for the slow readout path of the digitizer
package digitizer_pkg;

	// One signed ADC sample, also the width of each min and max result
	typedef logic signed [15:0] sample_t;

	// Software tag written over the local bus
	typedef logic [7:0] tag_t;

	// Unit of the slow chain, one byte per software read
	typedef logic [7:0] chain_byte_t;

	// Free-running adc_clk cycle count
	typedef logic [31:0] stamp_t;

	// Number of ADC channels in one adc_data word
	localparam int N_CHAN = 8;

	// Bytes loaded by a snapshot
	// Four per channel (min hi, min lo, max hi, max lo) plus tag_now and tag_old
	localparam int CHAIN_BYTES = 4 * N_CHAN + 2;

	// Timestamp bytes that follow the chain, shifted in one per read
	localparam int STAMP_BYTES = $bits(stamp_t) / $bits(chain_byte_t);

	// Chain width in bits
	localparam int CHAIN_W = CHAIN_BYTES * $bits(chain_byte_t);

endpackage

`default_nettype wire

// ==== minmax.sv ====
`timescale 1ns/1ps
`default_nettype none

// Running minimum and maximum of one signed channel
// A restart drops the history and seeds both extremes with the current sample
module minmax import digitizer_pkg::*; (
	input  wire          adc_clk,
	input  wire          rst_n,
	input  wire          restart,
	input  wire sample_t xin,
	output sample_t      xmin,
	output sample_t      xmax
);

	// Set while no sample has been seen since reset
	logic empty;

	// Outputs are the registers themselves, one cycle behind the sample
	always_ff @(posedge adc_clk) begin
		if (!rst_n) begin
			empty <= 1'b1;
			xmin  <= '0;
			xmax  <= '0;
		end else if (restart || empty) begin
			// First sample of a new interval sets both extremes
			empty <= 1'b0;
			xmin  <= xin;
			xmax  <= xin;
		end else begin
			// Signed compare, sample_t carries the sign
			if (xin < xmin) begin
				xmin <= xin;
			end
			if (xin > xmax) begin
				xmax <= xin;
			end
		end
	end

endmodule

`default_nettype wire

// ==== flag_xdomain.sv ====
`timescale 1ns/1ps
`default_nettype none

// Moves a one-cycle strobe from lb_clk into a one-cycle pulse in adc_clk
// The strobe flips a level, the level crosses, and an edge detector
// turns every flip back into a single pulse
// Works only for strobes spaced wider than the crossing latency
module flag_xdomain (
	input  wire lb_clk,
	input  wire adc_clk,
	input  wire rst_n,
	input  wire flag_in,
	output wire flag_out
);

	// Level in the lb_clk domain, flips once per strobe
	logic flag_tgl;

	// Two-flop synchronizer into adc_clk
	logic sync_a;
	logic sync_b;

	// Delayed copy of the synchronized level for edge detection
	logic sync_c;

	// Source side
	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			flag_tgl <= 1'b0;
		end else if (flag_in) begin
			flag_tgl <= ~flag_tgl;
		end
	end

	// Destination side
	// sync_a may go metastable, only sync_b and sync_c are used
	always_ff @(posedge adc_clk) begin
		if (!rst_n) begin
			sync_a <= 1'b0;
			sync_b <= 1'b0;
			sync_c <= 1'b0;
		end else begin
			sync_a <= flag_tgl;
			sync_b <= sync_a;
			sync_c <= sync_b;
		end
	end

	// Any change of the crossed level is one strobe
	// High for one adc_clk cycle, 2 to 3 cycles after the strobe
	assign flag_out = sync_b ^ sync_c;

endmodule

`default_nettype wire

// ==== timestamp.sv ====
`timescale 1ns/1ps
`default_nettype none

// Free-running adc_clk cycle counter with a byte-wide readout shifter
// A snapshot freezes the count, later slow operations move it out a byte at a time
module timestamp import digitizer_pkg::*; (
	input  wire     adc_clk,
	input  wire     rst_n,
	input  wire     slow_op,
	input  wire     slow_snap,
	output chain_byte_t shift_out
);

	// Cycle counter
	stamp_t count;

	// Latched count, most significant byte at the top index
	chain_byte_t [STAMP_BYTES-1:0] stamp_sr;

	// Zero on the first edge out of reset, plus one on every edge after
	always_ff @(posedge adc_clk) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			count <= count + stamp_t'(1);
		end
	end

	// Snapshot has priority over a read shift on the same edge
	// The value loaded is the count before this edge's increment
	always_ff @(posedge adc_clk) begin
		if (!rst_n) begin
			stamp_sr <= '0;
		end else if (slow_snap) begin
			stamp_sr <= count;
		end else if (slow_op) begin
			// Move up one byte, zero behind it
			stamp_sr <= {stamp_sr[STAMP_BYTES-2:0], chain_byte_t'(0)};
		end
	end

	// Next byte to enter the slow chain
	assign shift_out = stamp_sr[STAMP_BYTES-1];

endmodule

`default_nettype wire

// ==== digitizer_slowread.sv ====
`timescale 1ns/1ps
`default_nettype none

// Slow readout of an eight-channel 16-bit digitizer
// Tracks per-channel extremes in adc_clk, freezes them with tags on a snapshot
// and hands them to software a byte per read from the local bus clock
module digitizer_slowread import digitizer_pkg::*; (
	// Both clock domains share one synchronous reset
	input  wire                        adc_clk,
	input  wire                        lb_clk,
	input  wire                        rst_n,

	// Channel k sits in bits 16k up to 16k+15
	input  wire [N_CHAN*$bits(sample_t)-1:0] adc_data,

	// One-cycle adc_clk snapshot strobe
	input  wire                        slow_snap,

	// One-cycle lb_clk read strobe
	input  wire                        slow_read_lb,

	// Software tag, frozen into the chain at each snapshot
	input  wire tag_t                  tag_now,

	// Byte returned to the local bus
	output chain_byte_t                slow_chain_out
);

	localparam int SW = $bits(sample_t);
	localparam int BW = $bits(chain_byte_t);

	// Per-channel samples and results
	sample_t ch_x   [N_CHAN];
	sample_t ch_min [N_CHAN];
	sample_t ch_max [N_CHAN];

	// Parallel image loaded into the chain on a snapshot
	logic [CHAIN_W-1:0] snap_data;

	// The chain itself, top byte leaves first
	logic [CHAIN_W-1:0] slow_chain;

	// Tag as it was at the previous snapshot
	tag_t tag_old;

	// Read strobe after crossing into adc_clk
	wire slow_read_x;

	// Snapshot or read, either one moves the chain
	wire slow_op;

	// Timestamp byte waiting to enter the chain bottom
	chain_byte_t stamp_byte;

	// Byte currently at the chain top
	chain_byte_t chain_top;

	// One tracker per channel, all restarted by the snapshot
	for (genvar k = 0; k < N_CHAN; k++) begin : g_chan
		assign ch_x[k] = adc_data[k*SW +: SW];

		minmax minmax_i (
			.adc_clk (adc_clk),
			.rst_n   (rst_n),
			.restart (slow_snap),
			.xin     (ch_x[k]),
			.xmin    (ch_min[k]),
			.xmax    (ch_max[k])
		);

		// Channel 0 at the top, min before max, high byte first
		assign snap_data[CHAIN_W-1-k*2*SW -: 2*SW] = {ch_min[k], ch_max[k]};
	end

	// The two tags close the snapshot image
	assign snap_data[2*BW-1:0] = {tag_now, tag_old};

	// Read strobe into adc_clk
	flag_xdomain slow_read_xdomain (
		.lb_clk   (lb_clk),
		.adc_clk  (adc_clk),
		.rst_n    (rst_n),
		.flag_in  (slow_read_lb),
		.flag_out (slow_read_x)
	);

	assign slow_op = slow_snap | slow_read_x;

	// Cycle stamp latched at the snapshot, fed in behind the chain
	timestamp ts_i (
		.adc_clk   (adc_clk),
		.rst_n     (rst_n),
		.slow_op   (slow_op),
		.slow_snap (slow_snap),
		.shift_out (stamp_byte)
	);

	// Load on snapshot, otherwise shift up a byte on a read
	// A read landing on the snapshot edge is dropped
	always_ff @(posedge adc_clk) begin
		if (!rst_n) begin
			slow_chain <= '0;
			tag_old    <= '0;
		end else if (slow_snap) begin
			// Extremes here still cover the interval that ends now
			slow_chain <= snap_data;
			tag_old    <= tag_now;
		end else if (slow_read_x) begin
			slow_chain <= {slow_chain[CHAIN_W-BW-1:0], stamp_byte};
		end
	end

	assign chain_top = slow_chain[CHAIN_W-1 -: BW];

	// Sampled straight from the adc_clk chain
	// Safe because reads and snapshots keep well apart, so the top byte
	// is stable long before and after every read strobe
	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			slow_chain_out <= '0;
		end else if (slow_read_lb) begin
			slow_chain_out <= chain_top;
		end
	end

endmodule

`default_nettype wire

// ==== digitizer_slowread_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

// Properties of the slow readout path, bound into the RTL top
module digitizer_slowread_sva import digitizer_pkg::*; (
	input wire              adc_clk,
	input wire              lb_clk,
	input wire              rst_n,
	input wire              slow_read_lb,
	input wire              slow_read_x,
	input wire chain_byte_t slow_chain_out,
	input wire sample_t     ch_min [N_CHAN],
	input wire sample_t     ch_max [N_CHAN]
);

	// Crossed read strobe is a single-cycle pulse
	a_read_x_pulse: assert property (@(posedge adc_clk) disable iff (!rst_n)
		slow_read_x |=> !slow_read_x)
		else $error("slow_read_x high on two consecutive adc_clk cycles");

	// Extremes stay ordered, signed compare
	for (genvar k = 0; k < N_CHAN; k++) begin : g_chan
		a_order: assert property (@(posedge adc_clk) disable iff (!rst_n)
			ch_min[k] <= ch_max[k])
			else $error("channel %0d minimum above its maximum", k);
	end

	// Output register moves only on the edge that samples a read strobe
	a_out_hold: assert property (@(posedge lb_clk) disable iff (!rst_n)
		!$past(slow_read_lb) |-> $stable(slow_chain_out))
		else $error("slow_chain_out changed without a read strobe");

endmodule

bind digitizer_slowread digitizer_slowread_sva sva_i (
	.adc_clk        (adc_clk),
	.lb_clk         (lb_clk),
	.rst_n          (rst_n),
	.slow_read_lb   (slow_read_lb),
	.slow_read_x    (slow_read_x),
	.slow_chain_out (slow_chain_out),
	.ch_min         (ch_min),
	.ch_max         (ch_max)
);

`default_nettype wire

// ==== tb_digitizer_slowread.sv ====
`timescale 1ns/1ps
`default_nettype none

// Testbench for the slow readout path
// A model in adc_clk rebuilds the expected byte stream at every snapshot
module tb_digitizer_slowread import digitizer_pkg::*; ();

	localparam logic [31:0] SEED = 32'd83;

	// Upper bound on reads over all tests and the widest read gap in lb_clk cycles
	localparam int READ_BUDGET = 1100;
	localparam int MAX_GAP_LB  = 16;

	// Idle adc_clk cycles between snaps with some margin
	localparam int IDLE_ADC    = 20 * 200 + 1000;
	localparam int LIMIT_CYCLES = READ_BUDGET * MAX_GAP_LB * 14 / 10 + IDLE_ADC + 5000;

	logic                            adc_clk;
	logic                            lb_clk;
	logic                            rst_n;
	logic [N_CHAN*$bits(sample_t)-1:0] adc_data;
	logic                            slow_snap;
	logic                            slow_read_lb;
	tag_t                            tag_now;
	chain_byte_t                     slow_chain_out;

	// Separate random streams for control and samples
	logic [31:0] ctl_state;
	logic [31:0] smp_state;
	logic        run_samples;

	// Model state
	sample_t     m_min [N_CHAN];
	sample_t     m_max [N_CHAN];
	sample_t     m_x;
	logic        m_empty;
	stamp_t      m_count;
	tag_t        m_tag_old;
	chain_byte_t exp_q [$];
	int          read_pos;

	// Bookkeeping
	int pass_cnt;
	int fail_cnt;
	int test_num;
	int test_checks;
	int test_fails;
	int cycle_cnt;

	digitizer_slowread digitizer_slowread_i (
		.adc_clk        (adc_clk),
		.lb_clk         (lb_clk),
		.rst_n          (rst_n),
		.adc_data       (adc_data),
		.slow_snap      (slow_snap),
		.slow_read_lb   (slow_read_lb),
		.tag_now        (tag_now),
		.slow_chain_out (slow_chain_out)
	);

	// adc_clk at 10 ns
	initial begin
		adc_clk = 1'b0;
		forever #5 adc_clk = ~adc_clk;
	end

	// lb_clk at 14 ns drifts against adc_clk and lines up with it every 70 ns
	initial begin
		lb_clk = 1'b0;
		forever #7 lb_clk = ~lb_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Uniform integer in lo..hi from the control stream
	function automatic int rand_range(input int lo, input int hi);
		ctl_state = xorshift32(ctl_state);
		return lo + int'(ctl_state % 32'(hi - lo + 1));
	endfunction

	// New sample word on every falling adc_clk edge once running
	always @(negedge adc_clk) begin
		if (run_samples) begin
			for (int w = 0; w < N_CHAN / 2; w++) begin
				smp_state = xorshift32(smp_state);
				adc_data[w*32 +: 32] = smp_state;
			end
		end
	end

	// Reference model runs on the DUT's sampling edge
	always @(posedge adc_clk) begin
		if (!rst_n) begin
			m_empty   = 1'b1;
			m_count   = '0;
			m_tag_old = '0;
			exp_q.delete();
			for (int k = 0; k < N_CHAN; k++) begin
				m_min[k] = '0;
				m_max[k] = '0;
			end
		end else begin
			if (slow_snap) begin
				// Extremes of the interval closing at this edge
				exp_q.delete();
				for (int k = 0; k < N_CHAN; k++) begin
					exp_q.push_back(m_min[k][15:8]);
					exp_q.push_back(m_min[k][7:0]);
					exp_q.push_back(m_max[k][15:8]);
					exp_q.push_back(m_max[k][7:0]);
				end
				exp_q.push_back(tag_now);
				exp_q.push_back(m_tag_old);
				m_tag_old = tag_now;
				// Count before this edge's increment goes out high byte first
				for (int b = STAMP_BYTES - 1; b >= 0; b--) begin
					exp_q.push_back(m_count[b*8 +: 8]);
				end
				read_pos = 0;
			end
			for (int k = 0; k < N_CHAN; k++) begin
				m_x = sample_t'(adc_data[k*16 +: 16]);
				if (slow_snap || m_empty) begin
					m_min[k] = m_x;
					m_max[k] = m_x;
				end else begin
					if (m_x < m_min[k]) m_min[k] = m_x;
					if (m_x > m_max[k]) m_max[k] = m_x;
				end
			end
			m_empty = 1'b0;
			m_count = m_count + stamp_t'(1);
		end
	end

	// Watchdog
	always @(posedge adc_clk) begin
		cycle_cnt++;
		if (cycle_cnt > LIMIT_CYCLES) begin
			$display("Timeout: run still busy after %0d adc_clk cycles", cycle_cnt);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// One read strobe checked against the model and spanning gap lb_clk cycles in all
	task automatic read_and_check(input int gap);
		chain_byte_t exp_b;
		int          pos;
		@(negedge lb_clk);
		slow_read_lb = 1'b1;
		@(posedge lb_clk);
		// Past the end of the stream the chain reads zero
		if (exp_q.size() > 0) exp_b = exp_q.pop_front();
		else exp_b = '0;
		pos = read_pos;
		read_pos++;
		@(negedge lb_clk);
		slow_read_lb = 1'b0;
		test_checks++;
		assert (slow_chain_out == exp_b) begin
			pass_cnt++;
		end else begin
			$display("FAILED slow_chain_out expected %02h actual %02h at byte %0d",
				exp_b, slow_chain_out, pos);
			fail_cnt++;
			test_fails++;
		end
		repeat (gap - 1) @(negedge lb_clk);
	endtask

	// One-cycle snapshot pulse followed by a quiet time before the next read
	task automatic pulse_snap();
		@(negedge adc_clk);
		slow_snap = 1'b1;
		@(negedge adc_clk);
		slow_snap = 1'b0;
		repeat (8) @(negedge lb_clk);
	endtask

	task automatic set_tag();
		@(negedge lb_clk);
		tag_now = tag_t'(rand_range(0, 255));
	endtask

	task automatic begin_test();
		test_num++;
		test_checks = 0;
		test_fails  = 0;
	endtask

	task automatic report_test(input string name);
		$display("test %0d %s: %0d checks, %0d failed", test_num, name, test_checks,
			test_fails);
	endtask

	initial begin
		rst_n        = 1'b0;
		adc_data     = '0;
		slow_snap    = 1'b0;
		slow_read_lb = 1'b0;
		tag_now      = '0;
		run_samples  = 1'b0;
		ctl_state    = SEED;
		smp_state    = SEED ^ 32'h9e37_79b9;
		read_pos     = 0;
		pass_cnt     = 0;
		fail_cnt     = 0;
		test_num     = 0;
		cycle_cnt    = 0;
		repeat (4) @(negedge adc_clk);
		rst_n       = 1'b1;
		run_samples = 1'b1;

		// Chain and stamp register empty after reset
		begin_test();
		repeat (40) read_and_check(8);
		report_test("reads before any snapshot");

		// Two snaps 200 samples apart with tags moving in between
		begin_test();
		set_tag();
		pulse_snap();
		repeat (4) begin
			repeat (50) @(negedge adc_clk);
			set_tag();
		end
		pulse_snap();
		repeat (4 * N_CHAN) read_and_check(rand_range(8, 12));
		report_test("extremes between two snaps");

		begin_test();
		repeat (2) read_and_check(rand_range(8, 12));
		report_test("tag_now and tag_old");

		// Stamp bytes followed by zeros
		begin_test();
		repeat (STAMP_BYTES + 4) read_and_check(rand_range(8, 12));
		report_test("timestamp and trailing zeros");

		// Snap in the middle of a read sequence
		begin_test();
		repeat (100) @(negedge adc_clk);
		pulse_snap();
		repeat (10) read_and_check(rand_range(8, 14));
		set_tag();
		pulse_snap();
		repeat (CHAIN_BYTES + STAMP_BYTES + 2) read_and_check(rand_range(8, 14));
		report_test("snapshot during reads");

		// Random intervals and read spacing
		begin_test();
		repeat (20) begin
			repeat (rand_range(20, 200)) @(negedge adc_clk);
			set_tag();
			pulse_snap();
			repeat (rand_range(0, CHAIN_BYTES + STAMP_BYTES + 4)) begin
				read_and_check(rand_range(8, MAX_GAP_LB));
			end
		end
		report_test("random rounds");

		$display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
digitizer_pkg.sv
minmax.sv
flag_xdomain.sv
timestamp.sv
digitizer_slowread.sv
digitizer_slowread_sva.sv
tb_digitizer_slowread.sv

// ==== Makefile ====
# Verilator flow for the slow readout testbench

TOP = tb_digitizer_slowread

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

# Pass only if the log holds the pass line
sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
